// ==== rtl/store_stream_pkg.sv ====
/*
 * store streamer package
 * widths, job descriptor, status flags, memory request and FSM states
 */
package store_stream_pkg;

  localparam int unsigned STREAM_DW = 32;            // engine stream width
  localparam int unsigned MEM_DW    = STREAM_DW + 32; // extra word for misaligned shift
  localparam int unsigned ADDR_W    = 32;            // byte address width
  localparam int unsigned CNT_W     = 16;            // lengths and transaction count

  // job descriptor, held stable by software for the whole job
  typedef struct packed {
    logic              start;        // one-cycle start pulse
    logic [ADDR_W-1:0] base_addr;    // first byte address
    logic [CNT_W-1:0]  inner_len;    // words per inner run
    logic [ADDR_W-1:0] inner_stride; // bytes between words of a run
    logic [CNT_W-1:0]  outer_len;    // number of inner runs
    logic [ADDR_W-1:0] outer_stride; // bytes between run starts
    logic [CNT_W-1:0]  tot_len;      // inner_len * outer_len
  } store_ctrl_t;

  typedef struct packed {
    logic ready_start; // idle, start accepted
    logic done;        // single-cycle end of job
    logic gen_done;    // generator emitted its last address
  } store_flags_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr; // byte address, low bits select the lane
  } addr_entry_t;

  typedef struct packed {
    logic                req;
    logic [ADDR_W-1:0]   addr; // word aligned
    logic [MEM_DW-1:0]   data;
    logic [MEM_DW/8-1:0] be;
    logic                we;   // high for a store
  } mem_req_t;

  typedef enum logic [1:0] {
    st_idle,
    st_working,
    st_draining
  } sink_state_t;

endpackage

// ==== rtl/store_addr_gen.sv ====
/*
 * two-dimensional byte address generator
 * walks inner runs then outer steps from the base, one push per address
 */
`timescale 1ns/100ps

module store_addr_gen import store_stream_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        en_i,
  input  store_ctrl_t ctrl_i,
  input  logic        full_i,
  output logic        push_o,
  output addr_entry_t push_data_o,
  output logic        gen_done_o
);

  logic [CNT_W-1:0]  inner_cnt_q;
  logic [CNT_W-1:0]  outer_cnt_q;
  logic [ADDR_W-1:0] addr_off_q; // offset of the current address from base
  logic [ADDR_W-1:0] line_off_q; // offset of the current run start
  logic              done_q;
  logic              last_inner;
  logic              last_outer;

  assign last_inner = (inner_cnt_q == ctrl_i.inner_len - CNT_W'(1));
  assign last_outer = (outer_cnt_q == ctrl_i.outer_len - CNT_W'(1));

  // no push once done or while the FIFO is full
  assign push_o           = en_i & ~full_i & ~done_q;
  assign push_data_o.addr = ctrl_i.base_addr + addr_off_q;
  assign gen_done_o       = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inner_cnt_q <= '0;
      outer_cnt_q <= '0;
      addr_off_q  <= '0;
      line_off_q  <= '0;
      done_q      <= 1'b0;
    end else if (clear_i) begin
      inner_cnt_q <= '0;
      outer_cnt_q <= '0;
      addr_off_q  <= '0;
      line_off_q  <= '0;
      done_q      <= 1'b0;
    end else if (push_o) begin
      if (last_inner) begin
        inner_cnt_q <= '0;
        if (last_outer) begin
          done_q <= 1'b1; // last address just left
        end else begin
          outer_cnt_q <= outer_cnt_q + CNT_W'(1);
        end
        // next run starts one outer stride further
        line_off_q <= line_off_q + ctrl_i.outer_stride;
        addr_off_q <= line_off_q + ctrl_i.outer_stride;
      end else begin
        inner_cnt_q <= inner_cnt_q + CNT_W'(1);
        addr_off_q  <= addr_off_q + ctrl_i.inner_stride;
      end
    end
  end

endmodule

// ==== rtl/store_addr_fifo.sv ====
/*
 * address FIFO, first-word-fall-through
 * circular buffer with occupancy count and full/empty levels
 */
`timescale 1ns/100ps

module store_addr_fifo import store_stream_pkg::*; #(
  parameter int unsigned DEPTH = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        push_i,
  input  addr_entry_t push_data_i,
  input  logic        pop_i,
  output addr_entry_t pop_data_o,
  output logic        full_o,
  output logic        empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W_FIFO = $clog2(DEPTH + 1);

  addr_entry_t           mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q, rd_ptr_q;
  logic [CNT_W_FIFO-1:0] count_q;
  logic                  do_push, do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign full_o     = (count_q == CNT_W_FIFO'(DEPTH));
  assign empty_o    = (count_q == '0);
  assign pop_data_o = mem_q[rd_ptr_q]; // head shown combinationally

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + CNT_W_FIFO'(1);
        2'b01:   count_q <= count_q - CNT_W_FIFO'(1);
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

// ==== rtl/store_sink.sv ====
/*
 * store sink: job FSM, lane alignment and memory store issue
 * pairs each FIFO address with one stream word, counts stores, flags done
 */
`timescale 1ns/100ps

module store_sink import store_stream_pkg::*; #(
  parameter int unsigned MISALIGNED = 1
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  store_ctrl_t            ctrl_i,
  input  logic                   gen_done_i,
  input  logic                   empty_i,
  input  addr_entry_t            addr_i,
  input  logic                   stream_valid_i,
  input  logic [STREAM_DW-1:0]   stream_data_i,
  input  logic [STREAM_DW/8-1:0] stream_strb_i,
  input  logic                   mem_gnt_i,
  output logic                   gen_en_o,
  output logic                   gen_clr_o,
  output logic                   pop_o,
  output logic                   stream_ready_o,
  output mem_req_t               mem_o,
  output store_flags_t           flags_o
);

  localparam int unsigned MEM_BW = MEM_DW / 8;

  sink_state_t       cs_q, ns;
  logic [CNT_W-1:0]  cnt_q;   // completed stores
  logic              cnt_clr;
  logic              done_d, done_q;
  logic              active;
  logic              store_fire;
  logic [MEM_DW-1:0] data_al;
  logic [MEM_BW-1:0] strb_al;

  // lane alignment
  if (MISALIGNED == 1) begin : gen_misaligned
    // shift by low address bytes into the wide lane
    assign data_al = MEM_DW'(stream_data_i) << {addr_i.addr[1:0], 3'b000};
    assign strb_al = MEM_BW'(stream_strb_i) << addr_i.addr[1:0];
  end else begin : gen_aligned
    assign data_al = MEM_DW'(stream_data_i); // low word only, low bits ignored
    assign strb_al = MEM_BW'(stream_strb_i);
  end

  assign active = (cs_q != st_idle);

  // memory port, all zero while idle
  assign mem_o.req  = active & stream_valid_i & ~empty_i;
  assign mem_o.addr = active ? {addr_i.addr[ADDR_W-1:2], 2'b00} : '0;
  assign mem_o.data = active ? data_al : '0;
  assign mem_o.be   = active ? strb_al : '0;
  assign mem_o.we   = active;

  assign stream_ready_o = ~stream_valid_i | (mem_gnt_i & ~empty_i);
  assign store_fire     = mem_o.req & mem_gnt_i;
  assign pop_o          = store_fire; // one pop per store

  always_comb begin
    ns                  = cs_q;
    done_d              = 1'b0;
    cnt_clr             = 1'b0;
    gen_en_o            = 1'b0;
    gen_clr_o           = clear_i;
    flags_o.ready_start = 1'b0;
    case (cs_q)
      st_idle: begin
        flags_o.ready_start = 1'b1;
        if (ctrl_i.start) ns = st_working;
      end
      st_working: begin
        gen_en_o = 1'b1;
        if (gen_done_i) ns = st_draining; // all addresses generated
      end
      st_draining: begin
        gen_en_o = 1'b1;
        if (cnt_q == ctrl_i.tot_len) begin
          ns        = st_idle;
          done_d    = 1'b1;
          gen_en_o  = 1'b0;
          gen_clr_o = 1'b1; // rewind generator for next job
          cnt_clr   = 1'b1;
        end
      end
      default: ns = st_idle;
    endcase
  end

  assign flags_o.done     = done_q;
  assign flags_o.gen_done = gen_done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_q   <= st_idle;
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      cs_q   <= st_idle;
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      cs_q   <= ns;
      done_q <= done_d; // single-cycle pulse
      if (cnt_clr)         cnt_q <= '0;
      else if (store_fire) cnt_q <= cnt_q + CNT_W'(1);
    end
  end

endmodule

// ==== rtl/store_stream_top.sv ====
/*
 * store streamer top level
 * address generator feeds the address FIFO, sink pairs addresses with stream words
 */
`timescale 1ns/100ps

module store_stream_top import store_stream_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned MISALIGNED = 1
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  store_ctrl_t            ctrl_i,
  output store_flags_t           flags_o,
  input  logic                   stream_valid_i,
  input  logic [STREAM_DW-1:0]   stream_data_i,
  input  logic [STREAM_DW/8-1:0] stream_strb_i,
  output logic                   stream_ready_o,
  output mem_req_t               mem_o,
  input  logic                   mem_gnt_i
);

  logic        gen_en, gen_clr, gen_done;
  logic        push, pop;
  logic        fifo_full, fifo_empty;
  addr_entry_t push_data, pop_data;

  store_addr_gen i_addr_gen (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .clear_i     ( gen_clr   ), // includes the global clear
    .en_i        ( gen_en    ),
    .ctrl_i      ( ctrl_i    ),
    .full_i      ( fifo_full ),
    .push_o      ( push      ),
    .push_data_o ( push_data ),
    .gen_done_o  ( gen_done  )
  );

  store_addr_fifo #(
    .DEPTH ( FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .clear_i     ( clear_i    ),
    .push_i      ( push       ),
    .push_data_i ( push_data  ),
    .pop_i       ( pop        ),
    .pop_data_o  ( pop_data   ),
    .full_o      ( fifo_full  ),
    .empty_o     ( fifo_empty )
  );

  store_sink #(
    .MISALIGNED ( MISALIGNED )
  ) i_sink (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .ctrl_i         ( ctrl_i         ),
    .gen_done_i     ( gen_done       ),
    .empty_i        ( fifo_empty     ),
    .addr_i         ( pop_data       ),
    .stream_valid_i ( stream_valid_i ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .gen_en_o       ( gen_en         ),
    .gen_clr_o      ( gen_clr        ),
    .pop_o          ( pop            ),
    .stream_ready_o ( stream_ready_o ),
    .mem_o          ( mem_o          ),
    .flags_o        ( flags_o        )
  );

endmodule

// ==== sim/store_stream_checker.sv ====
/*
 * store streamer protocol checker
 * concurrent assertions on the memory port and the status flags
 */
`timescale 1ns/100ps

module store_stream_checker import store_stream_pkg::*; (
  input logic         clk_i,
  input logic         rst_ni,
  input store_ctrl_t  ctrl_i,
  input store_flags_t flags_i,
  input mem_req_t     mem_i,
  input logic         mem_gnt_i
);

  int unsigned fail_cnt = 0; // failed assertions so far
  logic        seen_start_q; // a job was started since reset

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_start_q <= 1'b0;
    end else if (ctrl_i.start) begin
      seen_start_q <= 1'b1;
    end
  end

  // a waiting store keeps request and payload until granted
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_i.req && !mem_gnt_i) |=> (mem_i.req && $stable(mem_i.addr)
      && $stable(mem_i.data) && $stable(mem_i.be)))
    else begin
      $error("memory request dropped or changed while grant was low");
      fail_cnt++;
    end

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_i.done |=> !flags_i.done)
    else begin
      $error("done stayed high for more than one cycle");
      fail_cnt++;
    end

  busy_no_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_i.req |-> !flags_i.ready_start)
    else begin
      $error("ready_start high while a store is requested");
      fail_cnt++;
    end

  no_early_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_start_q |-> !mem_i.req)
    else begin
      $error("store requested before any start");
      fail_cnt++;
    end

endmodule

bind store_stream_top store_stream_checker i_checker (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .ctrl_i    ( ctrl_i    ),
  .flags_i   ( flags_o   ),
  .mem_i     ( mem_o     ),
  .mem_gnt_i ( mem_gnt_i )
);

// ==== sim/tb_store_stream.sv ====
/*
 * store streamer testbench
 * runs jobs from the pattern file, drives stream and grant, checks each store
 */
`timescale 1ns/100ps

module tb_store_stream import store_stream_pkg::*; ();

  logic                   clk_i = 1'b0;
  logic                   rst_ni, clear_i;
  store_ctrl_t            ctrl_i;
  store_flags_t           flags_o;
  logic                   stream_valid_i, stream_ready_o;
  logic [STREAM_DW-1:0]   stream_data_i;
  logic [STREAM_DW/8-1:0] stream_strb_i;
  mem_req_t               mem_o;
  logic                   mem_gnt_i;

  logic [31:0]       rnd_state = 32'h48e2f85a;
  logic [7:0]        gnt_duty; // grant when random byte <= duty
  logic [3:0]        cur_strb;
  logic              word_taken; // stream handshake at the coming edge
  logic [31:0]       word_q [$];
  logic [31:0]       exp_addr_q [$];
  logic [MEM_DW-1:0] exp_data_q [$];
  logic [7:0]        exp_be_q [$];
  int                errors, timeouts, stores, checked, done_cnt;

  store_stream_top #(.FIFO_DEPTH(2), .MISALIGNED(1)) UUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_store();
    stores++;
    assert (exp_addr_q.size() > 0) else begin
      errors++;
      $display("store to %h issued with no store left to expect", mem_o.addr);
    end
    if (exp_addr_q.size() > 0) begin
      check_value("mem_o.addr", mem_o.addr, exp_addr_q.pop_front());
      check_value("mem_o.data", mem_o.data, exp_data_q.pop_front());
      check_value("mem_o.be", mem_o.be, exp_be_q.pop_front());
      check_value("mem_o.we", mem_o.we, 1);
      // last address left the generator before its store
      if (exp_addr_q.size() == 0) check_value("flags_o.gen_done", flags_o.gen_done, 1);
    end
  endtask

  // falling edges until ready_start or done, bounded by limit cycles
  task automatic wait_for(input bit want_done, input int limit, input string what);
    int n;
    n = 0;
    while ((want_done ? !flags_o.done : !flags_o.ready_start) && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    assert (want_done ? flags_o.done : flags_o.ready_start) else begin
      timeouts++;
      $display("timeout: %s within %0d cycles", what, limit);
    end
  endtask

  task automatic run_job(input logic [31:0] base, input logic [15:0] ilen,
                         input logic [31:0] istr, input logic [15:0] olen,
                         input logic [31:0] ostr, input logic [7:0] duty,
                         input logic [3:0] strb);
    logic [31:0] a;
    logic [31:0] w;
    logic [15:0] tot;
    tot = ilen * olen;
    wait_for(1'b0, 200, "ready_start before the job start");
    gnt_duty = duty;
    cur_strb = strb;
    for (int o = 0; o < olen; o++) begin // inner run first, then outer step
      for (int i = 0; i < ilen; i++) begin
        a = base + o * ostr + i * istr;
        rnd_state = xorshift32(rnd_state);
        w = rnd_state;
        word_q.push_back(w);
        exp_addr_q.push_back({a[31:2], 2'b00});
        exp_data_q.push_back(MEM_DW'(w) << (8 * a[1:0])); // byte lane shift
        exp_be_q.push_back(8'(strb) << a[1:0]);
      end
    end
    stores = 0;
    done_cnt = 0;
    @(posedge clk_i);
    #2;
    check_value("flags_o.ready_start", flags_o.ready_start, 1);
    ctrl_i = '{start: 1'b1, base_addr: base, inner_len: ilen, inner_stride: istr,
               outer_len: olen, outer_stride: ostr, tot_len: tot};
    @(posedge clk_i);
    #2 ctrl_i.start = 1'b0;
    @(negedge clk_i);
    check_value("flags_o.ready_start", flags_o.ready_start, 0);
    wait_for(1'b1, 40 * tot + 100, "done pulse after the last store");
    check_value("stores per job", stores, tot);
    check_value("expected stores left", exp_addr_q.size(), 0);
    wait_for(1'b0, 10, "ready_start after done");
    @(negedge clk_i);
    check_value("flags_o.done", flags_o.done, 0);
    check_value("flags_o.gen_done", flags_o.gen_done, 0); // generator rewound at job end
    check_value("done pulses per job", done_cnt, 1);
    checked += stores;
  endtask

  // grant and stream, driven shortly after the rising edge
  always @(posedge clk_i) begin
    #2;
    if (rst_ni) begin
      rnd_state = xorshift32(rnd_state);
      mem_gnt_i = (rnd_state[7:0] <= gnt_duty);
      if (stream_valid_i && word_taken) stream_valid_i = 1'b0;
      if (!stream_valid_i && word_q.size() > 0 && rnd_state[9:8] != 2'b00) begin
        stream_valid_i = 1'b1;
        stream_data_i  = word_q.pop_front();
        stream_strb_i  = cur_strb;
      end
    end
  end

  always @(negedge clk_i) begin
    word_taken = stream_valid_i && stream_ready_o;
    if (rst_ni) begin
      assert (word_taken == (mem_o.req && mem_gnt_i)) else begin
        errors++;
        $display("stream word taken and store issued did not happen together");
      end
      if (mem_o.req && mem_gnt_i) check_store();
      if (flags_o.done) done_cnt++;
    end
  end

  initial begin
    int fd, code, jobs;
    logic [8*128-1:0] line;
    logic [31:0] base, istr, ostr;
    logic [15:0] ilen, olen;
    logic [7:0]  duty;
    logic [3:0]  strb;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    ctrl_i = '0;
    stream_valid_i = 1'b0;
    stream_data_i = '0;
    stream_strb_i = '0;
    mem_gnt_i = 1'b0;
    gnt_duty = 8'hff;
    cur_strb = 4'hf;
    word_taken = 1'b0;
    {errors, timeouts, checked, jobs} = '0;
    repeat (5) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("flags_o.ready_start", flags_o.ready_start, 1);
    check_value("flags_o.done", flags_o.done, 0);
    check_value("flags_o.gen_done", flags_o.gen_done, 0);
    check_value("mem_o.req", mem_o.req, 0);
    check_value("stream_ready_o", stream_ready_o, 1);
    fd = $fopen("sim/store_patterns.txt", "r");
    assert (fd != 0) else begin
      errors++;
      $display("could not open the pattern file");
    end
    if (fd != 0) begin
      while (timeouts == 0 && $fgets(line, fd) != 0) begin
        code = $sscanf(line, "%h %h %h %h %h %h %h", base, ilen, istr, olen, ostr, duty, strb);
        if (code == 7) begin // comment and blank lines match nothing
          jobs++;
          run_job(base, ilen, istr, olen, ostr, duty, strb);
        end
      end
      $fclose(fd);
    end
    assert (jobs > 0) else begin
      errors++;
      $display("no job was read from the pattern file");
    end
    $display("jobs %0d, stores checked %0d, errors %0d, timeouts %0d, assertion failures %0d",
             jobs, checked, errors, timeouts, UUT.i_checker.fail_cnt);
    if (errors == 0 && timeouts == 0 && UUT.i_checker.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== Bender.yml ====
package:
  name: store_stream

sources:
  - rtl/store_stream_pkg.sv
  - rtl/store_addr_gen.sv
  - rtl/store_addr_fifo.sv
  - rtl/store_sink.sv
  - rtl/store_stream_top.sv
  - target: simulation
    files:
      - sim/store_stream_checker.sv
      - sim/tb_store_stream.sv

// ==== store_stream.f ====
rtl/store_stream_pkg.sv
rtl/store_addr_gen.sv
rtl/store_addr_fifo.sv
rtl/store_sink.sv
rtl/store_stream_top.sv
sim/store_stream_checker.sv
sim/tb_store_stream.sv

// ==== sim/store_patterns.txt ====
# one job per line, all fields hex, grant high when a random byte <= gnt_duty
# base inner_len inner_stride outer_len outer_stride gnt_duty strobe
00001000 8 4 1 0 ff f
00002000 6 8 1 0 ff f
# misaligned bases, low bits 1 2 3
00003001 4 4 1 0 ff f
00003102 4 4 1 0 c0 f
00003203 5 4 1 0 a0 f
00003303 3 4 1 0 ff 5
# two-dimensional walks
00004000 4 4 3 100 ff f
00005000 3 10 4 200 60 f
00006002 3 4 3 41 40 3
# long job under heavy back-pressure
00007000 10 4 1 0 30 c
